// ==== bench/spr_clk_gen.sv ====
// Free-running clock from time 0; reset is released on a rising edge after RST_CYCLES cycles
module spr_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;  // Released on the edge, like a synchronous driver
    end

endmodule

// ==== bench/spr_tb.sv ====
// ROM model decodes only addr[17:16] and addr[9:0]; tests keep banks 0 to 3 and offsets below 1024
module spr_tb;
    import spr_pkg::*;

    localparam int NUM_SPR = 16;
    localparam int IW      = $clog2(NUM_SPR);
    localparam int LIMIT   = 6 * (2 * 512 + NUM_SPR * 400);  // Cycle budget for the run

    logic                clk;
    logic                rst;
    logic                hstart;
    line_t               vline;
    logic                tbl_we;
    logic [IW-1:0]       tbl_addr;
    spr_entry_t          tbl_data;
    logic                rom_ok   = 1'b0;
    rom_word_t           rom_data = '0;
    xpos_t               pix_x;
    logic                rom_cs;
    rom_addr_t           rom_addr;
    buf_pix_t            pix;
    logic                line_done;

    rom_word_t  rom [4096];       // Graphics ROM contents
    spr_entry_t tbl_copy [NUM_SPR];
    buf_pix_t   image [512];      // Expected line
    int         seed;
    int         errors   = 0;
    int         checks   = 0;
    int         cycles   = 0;
    int         max_dly  = 3;     // ROM latency bound
    int         dly      = 0;
    int         wait_cnt = 0;
    logic       req_on   = 1'b0;  // Request pending in the last cycle
    rom_addr_t  req_addr = '0;    // Address of that request

    spr_clk_gen #(.PERIOD(40), .RST_CYCLES(3)) i_spr_clk_gen (.clk(clk), .rst(rst));

    spr_top #(
        .NUM_SPR (NUM_SPR)
    ) i_spr_top (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .vline     (vline),
        .tbl_we    (tbl_we),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .pix_x     (pix_x),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .pix       (pix),
        .line_done (line_done)
    );

    // Two bank bits over ten offset bits
    function automatic int rom_index(input rom_addr_t a);
        return int'({a[17:16], a[9:0]});
    endfunction

    function automatic int pick_delay();
        int r;
        r = $random(seed);
        return int'($unsigned(r) % (max_dly + 1));
    endfunction

    // ROM model, one word per request after dly idle cycles
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            wait_cnt <= 0;
        end else if (rom_ok) begin
            rom_ok <= 1'b0;  // Word taken on this edge
        end else if (wait_cnt >= dly) begin
            rom_ok   <= 1'b1;
            rom_data <= rom[rom_index(rom_addr)];
            wait_cnt <= 0;
            dly      <= pick_delay();
        end else begin
            wait_cnt <= wait_cnt + 1;
        end
    end

    // Unanswered request keeps rom_cs and rom_addr steady
    always @(posedge clk) begin
        if (req_on) begin
            checks++;
            assert (rom_cs) else begin
                errors++;
                $display("ERR %0t rom_cs got %b expected %b", $time, rom_cs, 1'b1);
            end
            checks++;
            assert (rom_addr == req_addr) else begin
                errors++;
                $display("ERR %0t rom_addr got %h expected %h", $time, rom_addr, req_addr);
            end
        end
        req_on   <= rom_cs && !rom_ok;
        req_addr <= rom_addr;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic spr_entry_t make_spr(input int ytop, input int height, input int xpos,
                                            input int base, input int stride, input int bank,
                                            input int hzoom, input bit hflip, input bit last);
        spr_entry_t e;
        e.ytop   = line_t'(ytop);
        e.height = 8'(height);
        e.xpos   = xpos_t'(xpos);
        e.base   = 16'(base);
        e.stride = 8'(stride);
        e.bank   = 4'(bank);
        e.prio   = 2'(bank + 1);     // Any value, only carried
        e.pal    = 7'(xpos + base);
        e.hzoom  = 5'(hzoom);
        e.hflip  = hflip;
        e.last   = last;
        return e;
    endfunction

    task automatic clear_table();
        for (int i = 0; i < NUM_SPR; i++) begin
            tbl_copy[i] = '0;  // Height 0, never visible
        end
    endtask

    // Row of nwords words: a hole at the second pixel, terminator only in the last word
    task automatic put_row(input int bank, input int off, input int nwords, input bit hflip);
        int        a;
        int        t;
        int        s;
        rom_word_t w;
        t = hflip ? 12 : 0;  // Fourth pixel taken
        s = hflip ? 4 : 8;   // Second pixel taken
        for (int k = 0; k < nwords; k++) begin
            a = rom_index({4'(bank), 16'(hflip ? off - k : off + k)});
            w = rom[a];
            if (k == 0) w[s +: 4] = TRANSPARENT;
            if (k == nwords - 1) begin
                w[t +: 4] = TRANSPARENT;
            end else if (w[t +: 4] == TRANSPARENT) begin
                w[t +: 4] = 4'h7;
            end
            rom[a] = w;
        end
    endtask

    // Expected pixels of one sprite row
    task automatic paint_sprite(input spr_entry_t e, input int row);
        int        off;
        int        x;
        int        acc;
        int        sum;
        int        w;
        int        n;
        rom_word_t word;
        pxl_t      px;
        bit        done;
        off  = (int'(e.base) + row * int'(e.stride)) & 16'hFFFF;
        x    = int'(e.xpos);
        acc  = int'(e.hzoom[3:0]) * 4;
        done = 1'b0;
        w    = 0;
        while (!done && w < 64) begin
            word = rom[rom_index({e.bank, 16'(off)})];
            for (int p = 0; p < 4; p++) begin
                n   = e.hflip ? p : 3 - p;
                px  = word[n * 4 +: 4];
                sum = acc + int'(e.hzoom);
                acc = sum % 64;
                if (sum < 64) begin  // Kept
                    if (px != TRANSPARENT) image[x & 511] = '{prio: e.prio, pal: e.pal, pxl: px};
                    x++;
                end
            end
            done = (px == TRANSPARENT);
            off  = e.hflip ? (off + 16'hFFFF) & 16'hFFFF : (off + 1) & 16'hFFFF;
            w++;
        end
    endtask

    task automatic build_image(input int v);
        int row;
        for (int x = 0; x < 512; x++) begin
            image[x] = '{prio: 2'd0, pal: 7'd0, pxl: TRANSPARENT};
        end
        for (int i = 0; i < NUM_SPR; i++) begin
            row = (v - int'(tbl_copy[i].ytop)) & 511;
            if (row < int'(tbl_copy[i].height)) paint_sprite(tbl_copy[i], row);
            if (tbl_copy[i].last) break;
        end
    endtask

    task automatic write_table();
        for (int i = 0; i < NUM_SPR; i++) begin
            @(posedge clk);
            tbl_we   <= 1'b1;
            tbl_addr <= IW'(i);
            tbl_data <= tbl_copy[i];
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    // pix_x parked at 0 so the swap edge clears nothing of the new front half
    task automatic pulse_hstart(input int v);
        @(posedge clk);
        hstart <= 1'b1;
        vline  <= line_t'(v);
        pix_x  <= '0;
        @(posedge clk);
        hstart <= 1'b0;
    endtask

    task automatic read_line(input bit check);
        for (int j = 0; j <= 512; j++) begin
            @(posedge clk);
            if (j < 511) pix_x <= xpos_t'(j + 1);
            if (check && j > 0) begin
                checks++;
                assert (pix == image[j - 1]) else begin
                    errors++;
                    $display("ERR %0t pix[%0d] got %h expected %h", $time, j - 1, pix,
                             image[j - 1]);
                end
            end
        end
    endtask

    task automatic run_line(input int v);
        int n;
        write_table();
        build_image(v);
        pulse_hstart(v);
        n = 0;
        while (!line_done && n < NUM_SPR * 400) begin
            @(posedge clk);
            n++;
        end
        checks++;
        assert (line_done) else begin
            errors++;
            $display("No line_done within %0d cycles for line %0d", n, v);
        end
        pulse_hstart(v);
        read_line(1'b1);
    endtask

    task automatic single_sprite();
        clear_table();
        tbl_copy[0] = make_spr(20, 8, 100, 64, 4, 1, 0, 1'b0, 1'b1);
        put_row(1, 76, 3, 1'b0);  // Row 3
        run_line(23);
    endtask

    task automatic flipped_sprite();
        clear_table();
        tbl_copy[0] = make_spr(40, 4, 200, 300, 8, 2, 0, 1'b1, 1'b1);
        put_row(2, 316, 3, 1'b1);  // Words 316 down to 314
        run_line(42);
    endtask

    task automatic sprite_list();
        clear_table();
        tbl_copy[0] = make_spr(10, 16, 50, 400, 3, 0, 0, 1'b0, 1'b0);
        tbl_copy[1] = make_spr(100, 8, 60, 450, 2, 0, 0, 1'b0, 1'b0); // Below the line
        tbl_copy[2] = make_spr(5, 20, 56, 500, 5, 3, 0, 1'b0, 1'b0);  // Covers x 56 and 57
        tbl_copy[3] = make_spr(0, 50, 58, 600, 1, 1, 0, 1'b1, 1'b1);
        tbl_copy[4] = make_spr(0, 100, 300, 700, 2, 0, 0, 1'b0, 1'b0); // Past the last entry
        put_row(0, 415, 2, 1'b0);
        put_row(3, 550, 3, 1'b0);
        put_row(1, 615, 2, 1'b1);
        put_row(0, 730, 2, 1'b0);
        run_line(15);
    endtask

    task automatic zoom_steps();
        clear_table();
        tbl_copy[0] = make_spr(0, 4, 20, 800, 4, 0, 31, 1'b0, 1'b0);
        tbl_copy[1] = make_spr(0, 4, 150, 900, 4, 2, 16, 1'b1, 1'b1);
        put_row(0, 808, 4, 1'b0);
        put_row(2, 908, 4, 1'b1);
        run_line(2);
    endtask

    task automatic empty_and_wrap();
        clear_table();
        tbl_copy[0] = make_spr(300, 10, 80, 20, 1, 0, 0, 1'b0, 1'b1);
        run_line(50);  // Nothing drawn
        tbl_copy[0] = make_spr(50, 2, 510, 950, 1, 3, 0, 1'b0, 1'b1);
        put_row(3, 950, 2, 1'b0);
        run_line(50);
    endtask

    task automatic slow_rom();
        max_dly = 12;
        single_sprite();
        max_dly = 3;
    endtask

    initial begin
        seed     = 32'h7044_ad2c;
        hstart   = 1'b0;
        vline    = '0;
        tbl_we   = 1'b0;
        tbl_addr = '0;
        tbl_data = '0;
        pix_x    = '0;
        for (int i = 0; i < 4096; i++) begin
            rom[i] = rom_word_t'($random(seed));
        end
        @(negedge rst);
        clear_table();
        write_table();
        // Read both halves once so every entry starts cleared
        pulse_hstart(0);
        read_line(1'b0);
        pulse_hstart(0);
        read_line(1'b0);
        single_sprite();
        flipped_sprite();
        sprite_list();
        zoom_steps();
        empty_and_wrap();
        slow_rom();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== design/spr_draw.sv ====
// hstart abandons any ROM request in flight; a row with no terminator word never ends
module spr_draw (
    input  logic                clk,
    input  logic                rst,
    input  logic                hstart,
    input  logic                start,
    input  spr_pkg::draw_cmd_t  cmd,
    input  logic                rom_ok,
    input  spr_pkg::rom_word_t  rom_data,
    output logic                busy,
    output logic                rom_cs,
    output spr_pkg::rom_addr_t  rom_addr,
    output logic                wr_en,
    output spr_pkg::xpos_t      wr_addr,
    output spr_pkg::buf_pix_t   wr_pix
);
    import spr_pkg::*;

    // Running copy of the command, xpos and offset advance as the row is drawn
    draw_cmd_t  cur;
    rom_word_t  word;     // Fetched pixels, shifted one nibble per cycle
    logic       drawing;  // Four pixel cycles after a fetch
    logic [1:0] pcnt;     // Pixel within word
    logic [5:0] zacc;     // Zoom accumulator
    logic [6:0] zsum;
    logic       drop;     // Pixel skipped by zoom
    logic       got;      // ROM word arrives
    logic       last_pix;
    pxl_t       pxl;

    assign got      = rom_cs & rom_ok;
    assign rom_addr = {cur.bank, cur.offset}; // Stable while rom_cs high
    assign last_pix = drawing && (pcnt == 2'd3);

    // Low nibble first when flipped
    assign pxl = cur.hflip ? word[3:0] : word[15:12];

    // Carry out of bit 6 drops the pixel
    assign zsum = {1'b0, zacc} + {2'b00, cur.hzoom};
    assign drop = zsum[6];

    // Write port, registered inside the line buffer
    assign wr_en   = drawing & ~drop & (pxl != TRANSPARENT);
    assign wr_addr = cur.xpos;
    assign wr_pix  = '{prio: cur.prio, pal: cur.pal, pxl: pxl};

    // Control flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            rom_cs  <= 1'b0;
            drawing <= 1'b0;
        end else if (hstart) begin
            // New line, drop the current sprite
            busy    <= 1'b0;
            rom_cs  <= 1'b0;
            drawing <= 1'b0;
        end else if (start) begin
            busy    <= 1'b1;
            rom_cs  <= 1'b1;  // First word of the row
            drawing <= 1'b0;
        end else if (busy) begin
            if (got) begin
                rom_cs  <= 1'b0;
                drawing <= 1'b1;
            end else if (last_pix) begin
                drawing <= 1'b0;
                // Transparent fourth pixel terminates the row
                if (pxl == TRANSPARENT) begin
                    busy <= 1'b0;
                end else begin
                    rom_cs <= 1'b1; // Next word right away
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            cur  <= cmd;
            zacc <= {cmd.hzoom[3:0], 2'b00};  // Zoom phase per sprite
        end else if (got) begin
            word <= rom_data;
            pcnt <= 2'd0;
        end else if (drawing) begin
            pcnt <= pcnt + 1'b1;
            zacc <= zsum[5:0];
            if (cur.hflip) begin
                word <= word >> 4;
            end else begin
                word <= word << 4;
            end
            // Dropped pixel takes no x step
            if (!drop) begin
                cur.xpos <= cur.xpos + 1'b1;
            end
            if (last_pix) begin
                // Descending words under hflip
                cur.offset <= cur.hflip ? cur.offset - 1'b1 : cur.offset + 1'b1;
            end
        end
    end

endmodule

// ==== design/spr_linebuf.sv ====
// Front half is read and cleared at pix_x every cycle, so pix_x must track video timing
module spr_linebuf (
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    input  logic              wr_en,
    input  spr_pkg::xpos_t    wr_addr,
    input  spr_pkg::buf_pix_t wr_pix,
    input  spr_pkg::xpos_t    pix_x,
    output spr_pkg::buf_pix_t pix
);
    import spr_pkg::*;

    // Value left behind by a read
    localparam buf_pix_t CLR = '{prio: 2'd0, pal: 7'd0, pxl: TRANSPARENT};

    buf_pix_t mem [2][512]; // Two line halves
    logic     sel;          // Front half index

    // One write port per half
    logic     we [2];
    xpos_t    wa [2];
    buf_pix_t wd [2];

    // Swap halves at line start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (hstart) begin
            sel <= ~sel;
        end
    end

    // Front half gets the clear, back half the draw writes
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            if (sel == 1'(h)) begin
                we[h] = 1'b1;
                wa[h] = pix_x;
                wd[h] = CLR;
            end else begin
                we[h] = wr_en;
                wa[h] = wr_addr;
                wd[h] = wr_pix;
            end
        end
    end

    always_ff @(posedge clk) begin
        pix <= mem[sel][pix_x];  // Old value, clear lands on the same edge
        for (int h = 0; h < 2; h++) begin
            if (we[h]) begin
                mem[h][wa[h]] <= wd[h];
            end
        end
    end

endmodule

// ==== design/spr_pkg.sv ====
// Sprite engine types; x positions wrap at 512 and pixel value 15 is never drawn
package spr_pkg;

    // Horizontal position in the line buffer, wraps mod 512
    typedef logic [8:0] xpos_t;
    typedef logic [8:0] line_t;      // Vertical line number

    typedef logic [19:0] rom_addr_t; // Bank over word offset
    typedef logic [15:0] rom_word_t; // Four pixels, first in 15:12
    typedef logic [3:0]  pxl_t;      // Colour index

    localparam pxl_t TRANSPARENT = 4'hF;

    // One line buffer entry
    typedef struct packed {
        logic [1:0] prio;  // Carried only
        logic [6:0] pal;
        pxl_t       pxl;
    } buf_pix_t;

    // Attribute table entry
    typedef struct packed {
        line_t       ytop;
        logic [7:0]  height;  // Rows
        xpos_t       xpos;
        logic [15:0] base;    // Word offset of row 0
        logic [7:0]  stride;  // Words per row
        logic [3:0]  bank;
        logic [1:0]  prio;
        logic [6:0]  pal;
        logic [4:0]  hzoom;
        logic        hflip;
        logic        last;    // End of table
    } spr_entry_t;

    // One sprite row for the draw engine
    typedef struct packed {
        xpos_t       xpos;
        logic [15:0] offset;  // Row start word
        logic [3:0]  bank;
        logic [1:0]  prio;
        logic [6:0]  pal;
        logic [4:0]  hzoom;
        logic        hflip;
    } draw_cmd_t;

    typedef enum logic [2:0] {IDLE, READ, TEST, ISSUE, WAIT} scan_state_t;

endpackage

// ==== design/spr_scan.sv ====
// Table writes may land at any time but change the entry being scanned; NUM_SPR must be >= 2
module spr_scan #(
    parameter int NUM_SPR = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hstart,
    input  spr_pkg::line_t             vline,
    input  logic                       tbl_we,
    input  logic [$clog2(NUM_SPR)-1:0] tbl_addr,
    input  spr_pkg::spr_entry_t        tbl_data,
    input  logic                       busy,
    output logic                       start,
    output spr_pkg::draw_cmd_t         cmd,
    output logic                       line_done
);
    import spr_pkg::*;

    localparam int IW = $clog2(NUM_SPR);

    spr_entry_t    tbl [NUM_SPR];  // Attribute table
    spr_entry_t    ent;            // Registered read of tbl[idx]
    scan_state_t   state;
    logic [IW-1:0] idx;
    line_t         line_q;         // Line being built
    line_t         row;
    logic          visible;
    logic          at_end;
    logic          advance;
    logic [15:0]   row_off;

    // Table memory, one write port, one synchronous read port
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            tbl[tbl_addr] <= tbl_data;
        end
        ent <= tbl[idx]; // Valid in TEST and WAIT
    end

    // Row inside the sprite; lines above ytop wrap to large values
    assign row     = line_q - ent.ytop;
    assign visible = row < {1'b0, ent.height};

    // Truncated to the 16 bit offset
    assign row_off = ent.base + row * ent.stride;

    assign at_end  = ent.last || (idx == IW'(NUM_SPR - 1));

    // Skip a hidden entry, or move on once the draw engine goes idle
    assign advance = ((state == TEST) && !visible) || ((state == WAIT) && !busy);

    assign start   = (state == ISSUE); // Single cycle, busy is low here

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            idx       <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (hstart) begin
                state <= READ; // Restart from entry 0
                idx   <= '0;
            end else begin
                unique case (state)
                    READ:    state <= TEST;
                    TEST:    if (visible) state <= ISSUE;
                    ISSUE:   state <= WAIT;  // busy rises next cycle
                    default: ;
                endcase
                if (advance) begin
                    if (at_end) begin
                        state     <= IDLE;
                        line_done <= 1'b1;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= READ;
                    end
                end
            end
        end
    end

    // Line latch and command register
    always_ff @(posedge clk) begin
        if (hstart) begin
            line_q <= vline;
        end
        if (state == TEST) begin
            // Held stable through ISSUE
            cmd <= '{
                xpos:   ent.xpos,
                offset: row_off,
                bank:   ent.bank,
                prio:   ent.prio,
                pal:    ent.pal,
                hzoom:  ent.hzoom,
                hflip:  ent.hflip
            };
        end
    end

endmodule

// ==== design/spr_top.sv ====
// ROM must answer every rom_cs with rom_ok; line_done comes once per hstart when the scan ends
module spr_top #(
    parameter int NUM_SPR = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hstart,
    input  spr_pkg::line_t             vline,
    input  logic                       tbl_we,
    input  logic [$clog2(NUM_SPR)-1:0] tbl_addr,
    input  spr_pkg::spr_entry_t        tbl_data,
    input  logic                       rom_ok,
    input  spr_pkg::rom_word_t         rom_data,
    input  spr_pkg::xpos_t             pix_x,
    output logic                       rom_cs,
    output spr_pkg::rom_addr_t         rom_addr,
    output spr_pkg::buf_pix_t          pix,
    output logic                       line_done
);
    import spr_pkg::*;

    // Scan to draw
    logic      start;
    logic      busy;
    draw_cmd_t cmd;

    // Draw to line buffer
    logic      wr_en;
    xpos_t     wr_addr;
    buf_pix_t  wr_pix;

    spr_scan #(
        .NUM_SPR (NUM_SPR)
    ) i_spr_scan (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .vline     (vline),
        .tbl_we    (tbl_we),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data),
        .busy      (busy),
        .start     (start),
        .cmd       (cmd),
        .line_done (line_done)
    );

    spr_draw i_spr_draw (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .start    (start),
        .cmd      (cmd),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .busy     (busy),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_pix   (wr_pix)
    );

    spr_linebuf i_spr_linebuf (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_pix  (wr_pix),
        .pix_x   (pix_x),
        .pix     (pix)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal -f src.f --top-module spr_tb \
    && ./obj_dir/Vspr_tb; } > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
exit 0

// ==== src.f ====
design/spr_pkg.sv
design/spr_scan.sv
design/spr_draw.sv
design/spr_linebuf.sv
design/spr_top.sv
bench/spr_clk_gen.sv
bench/spr_tb.sv
